// File: run.sh
#!/bin/sh
# Compile and run the quad-SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_qspim -f tb.f -o tb_qspim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_qspim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
exit 1

// File: source/qspim_clkgen.sv
/*
 * SPI clock divider, mode 0
 * Toggles spi_clk every CLK_DIV mclk cycles and flags each edge
 */
`timescale 1ns/1ps
`default_nettype none

module qspim_clkgen #(
    parameter int CLK_DIV = 2   // Half period in mclk cycles
) (
    input  wire logic mclk,
    input  wire logic rst_i,
    input  wire logic clk_en_i,
    output logic      spi_clk_o,
    output logic      rise_o,
    output logic      fall_o
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             clk_q, rise_q, fall_q;

    always_ff @(posedge mclk) begin
        if (rst_i) begin
            cnt_q  <= '0;
            clk_q  <= 1'b0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else if (!clk_en_i) begin
            cnt_q  <= '0;       // Restart the half period
            clk_q  <= 1'b0;     // Park low
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            if (cnt_q == CNT_W'(CLK_DIV - 1)) begin
                cnt_q  <= '0;
                clk_q  <= ~clk_q;
                rise_q <= ~clk_q;   // Low to high
                fall_q <= clk_q;    // High to low
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Pulses line up with the cycle the new level appears
    assign spi_clk_o = clk_q;
    assign rise_o    = rise_q;
    assign fall_o    = fall_q;

endmodule

`default_nettype wire

// File: source/qspim_ctrl.sv
/*
 * Flash read transaction controller
 * Pops requests, decodes chip select and sequences command, address, dummy, data
 */
`timescale 1ns/1ps
`default_nettype none

module qspim_ctrl (
    input  wire logic                        mclk,
    input  wire logic                        rst_i,
    input  wire logic                        fifo_empty_i,
    output logic                             fifo_rd_o,
    input  wire qspim_pkg::qspim_req_t       fifo_data_i,
    output logic                             clk_en_o,
    output qspim_pkg::qspim_phase_t          phase_o,
    output logic                             phase_start_o,
    input  wire logic                        phase_done_i,
    input  wire logic [qspim_pkg::DATA_W-1:0] rx_data_i,
    output logic [qspim_pkg::CS_N-1:0]       spi_csn_o,
    output logic                             rsp_valid_o,
    output logic [qspim_pkg::DATA_W-1:0]     rsp_data_o
);
    import qspim_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE, ST_POP, ST_SEL, ST_CSL, ST_CMD, ST_ADDR, ST_DUMMY, ST_DATA, ST_FIN
    } state_e;

    state_e            state_q, next_st;
    qspim_req_t        req_q;
    qspim_phase_t      phase_q;
    logic [CS_N-1:0]   csn_q;
    logic [DATA_W-1:0] rsp_data_q;
    logic              clk_en_q, start_q, rsp_valid_q;
    logic              phase_load;

    // Phase descriptor from state and request
    function automatic qspim_phase_t build_phase(input state_e st, input qspim_req_t req);
        qspim_phase_t     ph;
        logic [CMD_W-1:0] cmd;
        ph  = '0;
        cmd = (req.mode == MODE_QUAD) ? CMD_READ_QUAD : CMD_READ_SINGLE;
        case (st)
            ST_CMD: begin                                      // Always single line
                ph.tx_data = {cmd, {(DATA_W - CMD_W){1'b0}}};
                ph.bit_cnt = PH_CNT_W'(CMD_W);
                ph.tx      = 1'b1;
            end
            ST_ADDR: begin
                ph.tx_data = {req.addr[FLASH_AW-1:0], {(DATA_W - FLASH_AW){1'b0}}};
                ph.bit_cnt = PH_CNT_W'(FLASH_AW);
                ph.quad    = (req.mode == MODE_QUAD);
                ph.tx      = 1'b1;
            end
            ST_DUMMY: begin                                    // Quad only
                ph.bit_cnt = PH_CNT_W'(DUMMY_QUAD * LINES_N);
                ph.quad    = 1'b1;
                ph.idle    = 1'b1;
            end
            default: begin                                     // Read word
                ph.bit_cnt = PH_CNT_W'(DATA_W);
                ph.quad    = (req.mode == MODE_QUAD);
            end
        endcase
        return ph;
    endfunction

    // --------------------------------------------------
    // Phase sequencing
    // --------------------------------------------------
    always_comb begin
        case (state_q)
            ST_CSL:  next_st = ST_CMD;
            ST_CMD:  next_st = ST_ADDR;
            ST_ADDR: next_st = (req_q.mode == MODE_QUAD) ? ST_DUMMY : ST_DATA;
            default: next_st = ST_DATA;
        endcase
    end

    assign phase_load = (state_q == ST_CSL) ||
                        (phase_done_i && (state_q == ST_CMD || state_q == ST_ADDR ||
                                          state_q == ST_DUMMY));

    always_ff @(posedge mclk) begin
        if (rst_i) begin
            state_q     <= ST_IDLE;
            csn_q       <= '1;
            clk_en_q    <= 1'b0;
            start_q     <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            start_q     <= phase_load;  // Strobe along with the new descriptor
            rsp_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: if (!fifo_empty_i) state_q <= ST_POP;
                ST_POP:  state_q <= ST_SEL;
                ST_SEL: begin                                  // Pop data valid here
                    csn_q   <= ~(CS_N'(1) << fifo_data_i.addr[ADDR_W-1 -: CS_SEL_W]);
                    state_q <= ST_CSL;
                end
                ST_CSL: begin                                  // CS low, one cycle of lead
                    clk_en_q <= 1'b1;
                    state_q  <= next_st;
                end
                ST_CMD, ST_ADDR, ST_DUMMY: if (phase_load) state_q <= next_st;
                ST_DATA: if (phase_done_i) begin
                    csn_q       <= '1;
                    clk_en_q    <= 1'b0;
                    rsp_valid_q <= 1'b1;
                    state_q     <= ST_FIN;
                end
                ST_FIN:  state_q <= ST_IDLE;                   // CS high gap
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request, descriptor and read word
    always_ff @(posedge mclk) begin
        if (state_q == ST_SEL)
            req_q <= fifo_data_i;
        if (phase_load)
            phase_q <= build_phase(next_st, req_q);
        if (state_q == ST_DATA && phase_done_i)
            rsp_data_q <= rx_data_i;
    end

    assign fifo_rd_o     = (state_q == ST_POP);
    assign clk_en_o      = clk_en_q;
    assign phase_o       = phase_q;
    assign phase_start_o = start_q;
    assign spi_csn_o     = csn_q;
    assign rsp_valid_o   = rsp_valid_q;
    assign rsp_data_o    = rsp_data_q;

endmodule

`default_nettype wire

// File: source/qspim_fifo.sv
/*
 * Command FIFO for queued flash read requests
 * Circular buffer, registered read data updated on pop
 */
`timescale 1ns/1ps
`default_nettype none

module qspim_fifo #(
    parameter int CMD_DEPTH = 4
) (
    input  wire logic                   mclk,
    input  wire logic                   rst_i,
    input  wire logic                   wr_i,
    input  wire qspim_pkg::qspim_req_t  wr_data_i,
    input  wire logic                   rd_i,
    output qspim_pkg::qspim_req_t       rd_data_o,
    output logic                        empty_o
);
    import qspim_pkg::*;

    localparam int PTR_W = $clog2(CMD_DEPTH);
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    qspim_req_t       mem [CMD_DEPTH];
    qspim_req_t       rd_data_q;
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             wr_ok, rd_ok;

    assign empty_o   = (count_q == '0);
    assign wr_ok     = wr_i && (count_q != CNT_W'(CMD_DEPTH));  // Full drops the write
    assign rd_ok     = rd_i && !empty_o;
    assign rd_data_o = rd_data_q;

    always_ff @(posedge mclk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (rd_ok)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + CNT_W'(wr_ok) - CNT_W'(rd_ok);  // Net occupancy
        end
    end

    // Storage and output word
    always_ff @(posedge mclk) begin
        if (wr_ok)
            mem[wr_ptr_q] <= wr_data_i;
        if (rd_ok)
            rd_data_q <= mem[rd_ptr_q];  // Valid the cycle after the pop
    end

endmodule

`default_nettype wire

// File: source/qspim_pkg.sv
/*
 * Quad-SPI flash read master shared definitions
 * Request and shift phase types, line counts and flash read commands
 */
`default_nettype none

package qspim_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int ADDR_W   = 26;             // Chip select + flash address
    localparam int FLASH_AW = 24;             // Address sent on the bus
    localparam int CS_N     = 4;              // Chip selects
    localparam int CS_SEL_W = $clog2(CS_N);   // Upper address bits used for decode
    localparam int DATA_W   = 32;             // One read word
    localparam int LINES_N  = 4;              // IO0..IO3
    localparam int CMD_W    = 8;              // Command byte
    localparam int PH_CNT_W = 6;              // Phase bit counter, holds up to DATA_W

    // --------------------------------------------------
    // Flash read commands
    // --------------------------------------------------
    localparam logic [CMD_W-1:0] CMD_READ_SINGLE = 8'h03;  // Normal read
    localparam logic [CMD_W-1:0] CMD_READ_QUAD   = 8'hEB;  // Quad IO fast read
    localparam int               DUMMY_QUAD      = 4;      // SPI clocks after address

    // Transfer width of address and data
    typedef enum logic {
        MODE_SINGLE = 1'b0,
        MODE_QUAD   = 1'b1
    } qspim_mode_e;

    // Queued read request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // [25:24] chip, [23:0] flash byte address
        qspim_mode_e       mode;
    } qspim_req_t;

    // One shift phase as seen by the shifter
    typedef struct packed {
        logic [DATA_W-1:0]   tx_data;  // MSB first
        logic [PH_CNT_W-1:0] bit_cnt;  // Total bits of the phase
        logic                quad;     // 4 bits per SPI clock
        logic                tx;       // Drive lines, else receive
        logic                idle;     // Dummy clocks, lines released, nothing sampled
    } qspim_phase_t;

endpackage

`default_nettype wire

// File: source/qspim_shift.sv
/*
 * Serial shifter for one SPI phase
 * Drives 1 or 4 lines on falls, samples 1 or 4 lines on rises, owns line enables
 */
`timescale 1ns/1ps
`default_nettype none

module qspim_shift (
    input  wire logic                          mclk,
    input  wire logic                          rst_i,
    input  wire logic                          start_i,
    input  wire qspim_pkg::qspim_phase_t       phase_i,
    input  wire logic                          rise_i,
    input  wire logic                          fall_i,
    input  wire logic [qspim_pkg::LINES_N-1:0] sdi_i,
    output logic [qspim_pkg::LINES_N-1:0]      sdo_o,
    output logic [qspim_pkg::LINES_N-1:0]      oen_o,   // 1 = input
    output logic [qspim_pkg::DATA_W-1:0]       rx_data_o,
    output logic                               done_o
);
    import qspim_pkg::*;

    logic [DATA_W-1:0]   sh_q;
    logic [PH_CNT_W-1:0] cnt_q, step;
    logic                busy_q, armed_q, done_q;
    logic                quad_q, tx_q, idle_q;
    logic                drive;

    assign step  = quad_q ? PH_CNT_W'(LINES_N) : PH_CNT_W'(1);  // Bits per SPI clock
    assign drive = busy_q & tx_q;

    // --------------------------------------------------
    // Phase control
    // --------------------------------------------------
    always_ff @(posedge mclk) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            armed_q <= 1'b0;
            done_q  <= 1'b0;
            cnt_q   <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q  <= 1'b1;
                armed_q <= 1'b0;            // Ignore falls until the first rise
                cnt_q   <= phase_i.bit_cnt;
            end else if (busy_q && rise_i) begin
                armed_q <= 1'b1;
                cnt_q   <= cnt_q - step;
                if (cnt_q == step) begin    // Last bit or nibble
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Shift register and phase flags
    always_ff @(posedge mclk) begin
        if (start_i) begin
            sh_q   <= phase_i.tx_data;      // First bit out right away
            quad_q <= phase_i.quad;
            tx_q   <= phase_i.tx;
            idle_q <= phase_i.idle;
        end else if (busy_q && rise_i && !tx_q && !idle_q) begin
            if (quad_q)
                sh_q <= {sh_q[DATA_W-LINES_N-1:0], sdi_i};  // First nibble ends in 31:28
            else
                sh_q <= {sh_q[DATA_W-2:0], sdi_i[1]};       // MISO on IO1
        end else if (busy_q && armed_q && fall_i && tx_q) begin
            sh_q <= quad_q ? (sh_q << LINES_N) : (sh_q << 1);
        end
    end

    // --------------------------------------------------
    // Pads
    // --------------------------------------------------
    always_comb begin
        sdo_o = '0;
        if (drive) begin
            if (quad_q)
                sdo_o = sh_q[DATA_W-1 -: LINES_N];
            else
                sdo_o[0] = sh_q[DATA_W-1];  // MOSI on IO0
        end
    end

    assign oen_o[0]           = ~drive;
    assign oen_o[LINES_N-1:1] = {(LINES_N - 1){~(drive & quad_q)}};  // Quad tx only

    assign rx_data_o = sh_q;
    assign done_o    = done_q;

endmodule

`default_nettype wire

// File: source/qspim_top.sv
/*
 * Quad-SPI flash read master top level
 * Command FIFO, controller, SPI clock divider and line shifter
 */
`timescale 1ns/1ps
`default_nettype none

module qspim_top #(
    parameter int CMD_DEPTH = 4,   // Max requests in flight
    parameter int CLK_DIV   = 2    // SPI half period in mclk cycles
) (
    input  wire logic                           mclk,
    input  wire logic                           rst_i,
    // Requester
    input  wire logic                           req_valid_i,
    input  wire qspim_pkg::qspim_req_t          req_i,
    output logic                                rsp_valid_o,
    output logic [qspim_pkg::DATA_W-1:0]        rsp_data_o,
    // Flash pads
    output logic                                spi_clk_o,
    output logic [qspim_pkg::CS_N-1:0]          spi_csn_o,
    output logic [qspim_pkg::LINES_N-1:0]       spi_sdo_o,
    output logic [qspim_pkg::LINES_N-1:0]       spi_oen_o,
    input  wire logic [qspim_pkg::LINES_N-1:0]  spi_sdi_i
);
    import qspim_pkg::*;

    qspim_req_t        fifo_data;
    qspim_phase_t      phase;
    logic              fifo_empty, fifo_rd;
    logic              clk_en, spi_rise, spi_fall;
    logic              phase_start, phase_done;
    logic [DATA_W-1:0] rx_data;

    qspim_fifo #(.CMD_DEPTH(CMD_DEPTH)) u_cmd_fifo (
        .mclk      (mclk),
        .rst_i     (rst_i),
        .wr_i      (req_valid_i),
        .wr_data_i (req_i),
        .rd_i      (fifo_rd),
        .rd_data_o (fifo_data),
        .empty_o   (fifo_empty)
    );

    qspim_ctrl u_ctrl (
        .mclk          (mclk),
        .rst_i         (rst_i),
        .fifo_empty_i  (fifo_empty),
        .fifo_rd_o     (fifo_rd),
        .fifo_data_i   (fifo_data),
        .clk_en_o      (clk_en),
        .phase_o       (phase),
        .phase_start_o (phase_start),
        .phase_done_i  (phase_done),
        .rx_data_i     (rx_data),
        .spi_csn_o     (spi_csn_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (rsp_data_o)
    );

    qspim_clkgen #(.CLK_DIV(CLK_DIV)) u_clkgen (
        .mclk      (mclk),
        .rst_i     (rst_i),
        .clk_en_i  (clk_en),
        .spi_clk_o (spi_clk_o),
        .rise_o    (spi_rise),
        .fall_o    (spi_fall)
    );

    qspim_shift u_shift (
        .mclk      (mclk),
        .rst_i     (rst_i),
        .start_i   (phase_start),
        .phase_i   (phase),
        .rise_i    (spi_rise),
        .fall_i    (spi_fall),
        .sdi_i     (spi_sdi_i),
        .sdo_o     (spi_sdo_o),
        .oen_o     (spi_oen_o),
        .rx_data_o (rx_data),
        .done_o    (phase_done)
    );

endmodule

`default_nettype wire

// File: tb.f
source/qspim_pkg.sv
source/qspim_fifo.sv
source/qspim_clkgen.sv
source/qspim_shift.sv
source/qspim_ctrl.sv
source/qspim_top.sv
tests/qspim_flash_model.sv
tests/qspim_props.sv
tests/tb_qspim.sv

// File: tests/qspim_flash_model.sv
/*
 * Behavioral SPI flash for the read master testbench
 * Four chip selects sharing a 4 x 256 byte memory, single 0x03 and quad 0xEB reads
 */
`timescale 1ns/1ps
`default_nettype none

module qspim_flash_model (
    input  wire logic       spi_clk_i,
    input  wire logic [3:0] csn_i,
    input  wire logic [3:0] sdo_i,      // Master outputs
    output logic [3:0]      sdi_o,      // Master inputs
    output logic [7:0]      cmd_o,      // Last command byte seen
    output logic [15:0]     err_cnt_o
);

    localparam int DUMMY_CLKS  = 4;                  // Quad read dummy clocks
    localparam int START_SGL   = 8 + 24;             // Cmd + serial address
    localparam int START_QUAD  = 8 + 6 + DUMMY_CLKS; // Cmd + quad address + dummy

    logic [7:0]  mem [1024];      // {chip, byte address}, loaded by the testbench
    logic [7:0]  cmd_q   = '0;
    logic [23:0] addr_q  = '0;
    logic [1:0]  chip_q  = '0;
    logic        quad_q  = 1'b0;
    logic [3:0]  dout_q  = '0;
    logic [15:0] err_q   = '0;
    int          clk_cnt = 0;     // SPI clocks seen in this transfer
    logic        cs_idle;

    assign cs_idle   = &csn_i;
    assign sdi_o     = dout_q;
    assign cmd_o     = cmd_q;
    assign err_cnt_o = err_q;

    // --------------------------------------------------
    // Capture on rising edges
    // --------------------------------------------------
    always @(posedge spi_clk_i or posedge cs_idle) begin
        if (cs_idle) begin
            clk_cnt = 0;                                  // New transfer on next CS low
        end else begin
            assert ($onehot(~csn_i)) else begin
                $display("More than one chip select low during a transfer");
                err_q = err_q + 16'd1;
            end
            if (clk_cnt == 0) begin
                for (int c = 0; c < 4; c++)
                    if (!csn_i[c]) chip_q = 2'(c);        // Selected chip
            end
            if (clk_cnt < 8) begin
                cmd_q = {cmd_q[6:0], sdo_i[0]};           // Command always on IO0
                if (clk_cnt == 7) begin
                    assert (cmd_q == 8'h03 || cmd_q == 8'heb) else begin
                        $display("Fail flash command: got %h expected 03 or eb", cmd_q);
                        err_q = err_q + 16'd1;
                    end
                    quad_q = (cmd_q == 8'heb);
                end
            end else if (!quad_q && clk_cnt < START_SGL) begin
                addr_q = {addr_q[22:0], sdo_i[0]};
            end else if (quad_q && clk_cnt < 14) begin
                addr_q = {addr_q[19:0], sdo_i};           // MSB nibble first
            end
            clk_cnt = clk_cnt + 1;
        end
    end

    // Data out on falling edges, mode 0
    always @(negedge spi_clk_i) begin
        int         idx;
        logic [7:0] ba, b;
        if (!cs_idle && clk_cnt >= (quad_q ? START_QUAD : START_SGL)) begin
            idx = clk_cnt - (quad_q ? START_QUAD : START_SGL);
            if (quad_q) begin
                ba     = addr_q[7:0] + 8'(idx / 2);       // Wraps per chip
                b      = mem[{chip_q, ba}];
                dout_q = (idx % 2 == 0) ? b[7:4] : b[3:0];
            end else begin
                ba     = addr_q[7:0] + 8'(idx / 8);
                b      = mem[{chip_q, ba}];
                dout_q = {2'b00, b[7 - (idx % 8)], 1'b0}; // MISO on IO1
            end
        end else begin
            dout_q = '0;
        end
    end

endmodule

`default_nettype wire

// File: tests/qspim_props.sv
/*
 * Bound assertions for the read master pads
 * Chip select shape and line enable rules
 */
`timescale 1ns/1ps
`default_nettype none

module qspim_props (
    input wire logic                          mclk,
    input wire logic                          rst_i,
    input wire logic [qspim_pkg::CS_N-1:0]    spi_csn_i,
    input wire logic [qspim_pkg::LINES_N-1:0] spi_oen_i,
    input wire qspim_pkg::qspim_mode_e        mode_i      // Request in service
);
    import qspim_pkg::*;

    // At most one chip low
    a_cs_onehot: assert property (@(posedge mclk) disable iff (rst_i)
        $onehot0(~spi_csn_i)) else $error("More than one chip select low");

    // Selected chip held for the whole transfer
    a_cs_stable: assert property (@(posedge mclk) disable iff (rst_i)
        (spi_csn_i != '1 && $past(spi_csn_i) != '1) |-> spi_csn_i == $past(spi_csn_i))
        else $error("Chip select changed inside a transfer");

    a_cs_gap: assert property (@(posedge mclk) disable iff (rst_i)
        $rose(&spi_csn_i) |=> &spi_csn_i) else $error("No idle cycle after chip select rose");

    a_idle_inputs: assert property (@(posedge mclk) disable iff (rst_i)
        &spi_csn_i |-> &spi_oen_i) else $error("Line driven with all chip selects high");

    // IO1..IO3 stay inputs for a single mode read
    a_upper_lines: assert property (@(posedge mclk) disable iff (rst_i)
        (mode_i == MODE_SINGLE) |-> &spi_oen_i[LINES_N-1:1])
        else $error("Upper lines driven during a single mode read");

endmodule

`default_nettype wire

// File: tests/tb_qspim.sv
/*
 * Testbench for the quad-SPI flash read master
 * Random single, quad and mixed burst reads against a flash model and a scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

module tb_qspim;
    import qspim_pkg::*;

    localparam int CMD_DEPTH   = 4;
    localparam int CLK_DIV     = 2;
    localparam int SEED        = 61755;
    localparam int N_SINGLE    = 12;
    localparam int N_QUAD      = 12;
    localparam int N_BURSTS    = 4;
    localparam int N_REQ       = N_SINGLE + N_QUAD + N_BURSTS * CMD_DEPTH;  // 40
    // Worst case single read is 64 SPI clocks of 2*CLK_DIV cycles plus setup
    localparam int REQ_CYC     = 128 * CLK_DIV + 40;
    localparam int TIMEOUT_CYC = N_REQ * REQ_CYC;
    localparam logic [7:0] EXP_CMD_SINGLE = 8'h03;
    localparam logic [7:0] EXP_CMD_QUAD   = 8'heb;

    typedef struct packed {
        logic [31:0] data;   // Predicted word
        logic [1:0]  chip;
        logic        quad;
    } expect_t;

    logic              mclk      = 1'b0;
    logic              rst       = 1'b1;
    logic              req_valid = 1'b0;
    qspim_req_t        req       = '0;
    logic              rsp_valid, spi_clk;
    logic [31:0]       rsp_data;
    logic [3:0]        spi_csn, spi_sdo, spi_oen, spi_sdi;
    logic [7:0]        flash_cmd;
    logic [15:0]       flash_err;
    logic [7:0]        ref_mem [1024];   // Copy of the flash contents
    expect_t           exp_q [$];
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int                n_tests = 0;

    always #10 mclk = ~mclk;

    qspim_top #(.CMD_DEPTH(CMD_DEPTH), .CLK_DIV(CLK_DIV)) uut (
        .mclk        (mclk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_data_o  (rsp_data),
        .spi_clk_o   (spi_clk),
        .spi_csn_o   (spi_csn),
        .spi_sdo_o   (spi_sdo),
        .spi_oen_o   (spi_oen),
        .spi_sdi_i   (spi_sdi)
    );

    qspim_flash_model flash (
        .spi_clk_i (spi_clk),
        .csn_i     (spi_csn),
        .sdo_i     (spi_sdo),
        .sdi_o     (spi_sdi),
        .cmd_o     (flash_cmd),
        .err_cnt_o (flash_err)
    );

    bind qspim_top qspim_props u_props (
        .mclk      (mclk),
        .rst_i     (rst_i),
        .spi_csn_i (spi_csn_o),
        .spi_oen_i (spi_oen_o),
        .mode_i    (u_ctrl.req_q.mode)
    );

    function automatic int total_errors();
        return errors + int'(flash_err);
    endfunction

    // Four consecutive bytes of one chip, first byte on top
    function automatic logic [31:0] predict_word(input logic [1:0] chip, input logic [7:0] base);
        logic [31:0] w;
        logic [7:0]  ba;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            ba = base + 8'(k);                           // Wraps modulo 256
            w  = {w[23:0], ref_mem[{chip, ba}]};
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // n strobes on consecutive cycles, mode 0 single, 1 quad, 2 random
    task automatic send_burst(input int n, input int mode_sel);
        logic [ADDR_W-1:0] a;
        logic              q;
        expect_t           e;
        for (int k = 0; k < n; k++) begin
            @(posedge mclk);
            #1;
            a         = ADDR_W'($urandom);
            q         = (mode_sel == 2) ? 1'($urandom % 2) : (mode_sel == 1);
            req.addr  = a;
            req.mode  = q ? MODE_QUAD : MODE_SINGLE;
            req_valid = 1'b1;
            e.data    = predict_word(a[25:24], a[7:0]);
            e.chip    = a[25:24];
            e.quad    = q;
            exp_q.push_back(e);
        end
        @(posedge mclk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(negedge mclk);
    endtask

    task automatic report_test(input string name, input int err_before);
        n_tests++;
        $display("Test %s: %0d errors", name, total_errors() - err_before);
    endtask

    // --------------------------------------------------
    // Scoreboard and chip select monitor
    // --------------------------------------------------
    always @(negedge mclk) begin
        expect_t    e;
        logic [3:0] cs_exp;
        cycles++;
        if (cycles > TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Done: errors found");
            $finish;
        end else if (!rst) begin
            if (spi_csn != 4'hf) begin
                if (exp_q.size() == 0) begin
                    $display("Chip select low with no request pending");
                    errors++;
                end else begin
                    for (int c = 0; c < 4; c++)
                        cs_exp[c] = (c != exp_q[0].chip);   // Chip from addr 25:24
                    check_value("spi_csn_o", 32'(spi_csn), 32'(cs_exp));
                end
            end
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Response strobe with no request pending");
                    errors++;
                end else begin
                    e = exp_q.pop_front();               // In order
                    check_value("rsp_data_o", rsp_data, e.data);
                    check_value("flash command", 32'(flash_cmd),
                                32'(e.quad ? EXP_CMD_QUAD : EXP_CMD_SINGLE));
                end
            end
        end
    end

    initial begin
        logic [7:0] fill_b;
        int         err0;
        fill_b = 8'($urandom(SEED));                     // Seed once
        for (int i = 0; i < 1024; i++) begin
            fill_b     = 8'($urandom);
            ref_mem[i] = fill_b;
            flash.mem[i] = fill_b;
        end
        repeat (2) @(posedge mclk);
        #1;
        rst = 1'b0;

        // Idle pads after reset
        err0 = total_errors();
        @(negedge mclk);
        check_value("spi_csn_o", 32'(spi_csn), 32'h0000000f);
        check_value("rsp_valid_o", 32'(rsp_valid), 32'h0);
        check_value("spi_oen_o", 32'(spi_oen), 32'h0000000f);
        check_value("spi_clk_o", 32'(spi_clk), 32'h0);
        report_test("reset", err0);

        err0 = total_errors();
        for (int n = 0; n < N_SINGLE; n++) begin
            send_burst(1, 0);
            wait_drained();
        end
        report_test("single reads", err0);

        err0 = total_errors();
        for (int n = 0; n < N_QUAD; n++) begin
            send_burst(1, 1);
            wait_drained();
        end
        report_test("quad reads", err0);

        // Full queue of mixed modes
        err0 = total_errors();
        for (int n = 0; n < N_BURSTS; n++) begin
            send_burst(CMD_DEPTH, 2);
            wait_drained();
        end
        report_test("mixed bursts", err0);

        repeat (4) @(negedge mclk);
        $display("Tests %0d, checks %0d, errors %0d", n_tests, checks, total_errors());
        if (total_errors() == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
